//--- flist.f
logic/an_pkg.sv
logic/lacr_rx_filter.sv
logic/an_timers.sv
logic/an_arbiter.sv
logic/lacr_tx_encode.sv
logic/an_top.sv
sim/tb_clock_gen.sv
sim/an_tb.sv

//--- logic/an_arbiter.sv
`timescale 1ns/10ps
//############################################################
// Clause 37 arbitration FSM
// Link timer requests, forward progress for the watchdog
// Registered transmit and operate controls
//############################################################
module an_arbiter (
   input  logic              rx_clk,
   input  logic              an_rst,
   input  logic              los,
   input  logic              link_det,
   input  logic              abl_match,
   input  logic              ack_match,
   input  logic              consistency_match,
   input  logic              breaklink_seen,
   input  logic              link_timer_on,
   input  logic              link_timer_done,
   input  logic              wdog_timeout,
   input  logic              wdog_an_disable,
   output an_pkg::an_state_e an_state,
   output logic              link_timer_start,
   output logic              fwd_progress,
   output logic              lacr_send,
   output logic              send_ack,
   output logic              send_breaklink,
   output logic              operate
);
   an_pkg::an_state_e n_state;
   an_pkg::an_state_e state_q;       // State one cycle ago
   logic              force_restart;
   logic              state_entry;   // First cycle in a state
   logic              timed_state;   // States that run the link timer
   logic              timer_expired;

   // Partner breaklink ignored once the watchdog gave up
   assign force_restart = los || wdog_timeout || (breaklink_seen && !wdog_an_disable);

   assign state_entry   = (an_state != state_q);
   assign timed_state   = (an_state == an_pkg::AN_RESTART) ||
                          (an_state == an_pkg::AN_ACK) ||
                          (an_state == an_pkg::AN_IDLE);
   assign timer_expired = link_timer_done && !state_entry; // Ignore stale done

   // Fresh timer on entry, rerun whenever idle
   assign link_timer_start = timed_state &&
                             (state_entry || (!link_timer_on && !link_timer_done));

   always_comb begin
      n_state = an_state;
      case (an_state)
         an_pkg::AN_RESTART: begin
            if (timer_expired && link_det)
               n_state = wdog_an_disable ? an_pkg::AN_ABORT : an_pkg::AN_ABILITY;
         end
         an_pkg::AN_ABILITY: begin
            if (abl_match) n_state = an_pkg::AN_ACK;
         end
         an_pkg::AN_ACK: begin
            if (timer_expired && ack_match)
               n_state = consistency_match ? an_pkg::AN_IDLE : an_pkg::AN_RESTART;
         end
         an_pkg::AN_IDLE: begin
            if (timer_expired) n_state = an_pkg::AN_LINK_OK; // Idle always matched
         end
         an_pkg::AN_LINK_OK: n_state = an_pkg::AN_LINK_OK;
         default:            n_state = an_pkg::AN_ABORT; // Stay until restart
      endcase
   end

   // ABILITY to ACK, ACK to IDLE, IDLE to LINK_OK
   assign fwd_progress = !force_restart && (n_state != an_state) &&
                         (n_state != an_pkg::AN_RESTART) &&
                         ((an_state == an_pkg::AN_ABILITY) ||
                          (an_state == an_pkg::AN_ACK) ||
                          (an_state == an_pkg::AN_IDLE));

   always_ff @(posedge rx_clk) begin
      if (an_rst) begin
         an_state <= an_pkg::AN_RESTART;
         state_q  <= an_pkg::AN_RESTART;
      end else begin
         state_q <= an_state;
         if (force_restart) an_state <= an_pkg::AN_RESTART;
         else an_state <= n_state;
      end
   end

   // Controls trail the state by one cycle
   always_ff @(posedge rx_clk) begin
      if (an_rst) begin
         send_breaklink <= 1'b1; // Breaklink out of reset
         send_ack       <= 1'b0;
         lacr_send      <= 1'b1;
         operate        <= 1'b0;
      end else begin
         send_breaklink <= (an_state == an_pkg::AN_RESTART);
         send_ack       <= (an_state == an_pkg::AN_ACK) || (an_state == an_pkg::AN_IDLE);
         lacr_send      <= (an_state == an_pkg::AN_RESTART) ||
                           (an_state == an_pkg::AN_ABILITY) ||
                           (an_state == an_pkg::AN_ACK);
         operate        <= (an_state == an_pkg::AN_LINK_OK) ||
                           (an_state == an_pkg::AN_ABORT);
      end
   end

   // Operate lags a cycle, so only a restart may already show
   a_operate_state: assert property (@(posedge rx_clk) disable iff (an_rst)
      operate |-> (an_state == an_pkg::AN_LINK_OK) ||
                  (an_state == an_pkg::AN_ABORT) ||
                  (an_state == an_pkg::AN_RESTART));

endmodule

//--- logic/an_pkg.sv
//############################################################
// Types for the Clause 37 auto-negotiation block
// Config word and status vector bit positions
// Advertised local ability
//############################################################
package an_pkg;

   typedef logic [15:0] lacr_t;      // One config register word
   typedef logic [8:0]  an_status_t; // Status to management

   // Arbitration states
   typedef enum logic [2:0] {
      AN_RESTART = 3'd0,
      AN_ABILITY = 3'd1, // Ability detect
      AN_ACK     = 3'd2, // Ack detect and complete ack
      AN_IDLE    = 3'd3,
      AN_LINK_OK = 3'd4,
      AN_ABORT   = 3'd5  // Watchdog gave up
   } an_state_e;

   // Config register bits
   localparam int NP_BIT  = 15; // Next page
   localparam int ACK_BIT = 14;
   localparam int RF2_BIT = 13; // Remote fault pair
   localparam int RF1_BIT = 12;
   localparam int PS2_BIT = 8;  // Pause pair
   localparam int PS1_BIT = 7;
   localparam int HD_BIT  = 6;  // Half duplex
   localparam int FD_BIT  = 5;  // Full duplex

   // Status vector, top bit down
   localparam int ST_ABORT        = 8;
   localparam int ST_ABILITY      = 7;
   localparam int ST_WDOG_DIS     = 6;
   localparam int ST_RF2          = 5; // Partner remote fault
   localparam int ST_RF1          = 4;
   localparam int ST_ABL_MISMATCH = 3; // Partner lacks full duplex
   localparam int ST_ACK          = 2;
   localparam int ST_IDLE         = 1;
   localparam int ST_LINK_OK      = 0;

   // Full duplex only, no pause, no next page
   localparam lacr_t LOCAL_ABILITY = lacr_t'(1 << FD_BIT);

endpackage

//--- logic/an_timers.sv
`timescale 1ns/10ps
//############################################################
// Link timer with start and done pulses
// Watchdog for negotiation that makes no progress
//############################################################
module an_timers #(
   parameter int TIMER_TICKS = 1250000 // 10 ms at 125 MHz
) (
   input  logic rx_clk,
   input  logic an_rst,
   input  logic los,
   input  logic link_det,
   input  logic link_timer_start,
   input  logic fwd_progress,
   input  logic link_ok,
   output logic link_timer_on,
   output logic link_timer_done,
   output logic wdog_timeout,
   output logic wdog_an_disable
);
   localparam int LT_W     = $clog2(TIMER_TICKS + 1);
   localparam int WD_TICKS = 8 * TIMER_TICKS; // Watchdog length
   localparam int WD_W     = $clog2(WD_TICKS + 1);

   logic [LT_W-1:0] lt_cnt;
   logic [WD_W-1:0] wd_cnt;

   // Done lands TIMER_TICKS+1 cycles after start
   always_ff @(posedge rx_clk) begin
      if (an_rst) begin
         lt_cnt          <= '0;
         link_timer_on   <= 1'b0;
         link_timer_done <= 1'b0;
      end else begin
         link_timer_done <= 1'b0;
         if (link_timer_start) begin
            lt_cnt        <= LT_W'(TIMER_TICKS); // Reload, also mid-count
            link_timer_on <= 1'b1;
         end else if (link_timer_on) begin
            lt_cnt <= lt_cnt - 1'b1;
            if (lt_cnt == LT_W'(1)) begin
               link_timer_done <= 1'b1;
               link_timer_on   <= 1'b0;
            end
         end
      end
   end

   // Counts only with a partner present and the link not up
   always_ff @(posedge rx_clk) begin
      if (an_rst || los) begin
         wd_cnt          <= '0;
         wdog_timeout    <= 1'b0;
         wdog_an_disable <= 1'b0; // Loss of signal re-arms negotiation
      end else begin
         wdog_timeout <= 1'b0;
         if (fwd_progress) begin
            wd_cnt          <= '0;
            wdog_an_disable <= 1'b0;
         end else if (link_det && !link_ok && !wdog_an_disable) begin
            if (wd_cnt == WD_W'(WD_TICKS - 1)) begin
               wd_cnt          <= '0;
               wdog_timeout    <= 1'b1; // Single pulse
               wdog_an_disable <= 1'b1; // Held until los
            end else begin
               wd_cnt <= wd_cnt + 1'b1;
            end
         end
      end
   end

   a_done_single: assert property (@(posedge rx_clk) disable iff (an_rst)
      link_timer_done |=> !link_timer_done);

endmodule

//--- logic/an_top.sv
`timescale 1ns/10ps
//############################################################
// 1000BASE-X auto-negotiation top level
// Filter, timers, arbiter and encoder on rx_clk
//############################################################
module an_top #(
   parameter int TIMER_TICKS = 1250000
) (
   input  logic               rx_clk,
   input  logic               an_rst,
   input  logic               los,       // Loss of signal
   input  an_pkg::lacr_t      lacr_in,
   input  logic               lacr_in_stb,
   output an_pkg::lacr_t      lacr_out,
   output logic               lacr_send,
   output logic               operate,   // Upper layers enabled
   output an_pkg::an_status_t an_status
);
   logic link_det, match_ok, abl_match, ack_match, consistency_match, breaklink_seen;
   logic link_timer_start, link_timer_on, link_timer_done, fwd_progress, link_ok;
   logic wdog_timeout, wdog_an_disable, send_ack, send_breaklink;
   an_pkg::lacr_t     lacr_prev, lacr_ability;
   an_pkg::an_state_e an_state;

   assign link_ok = (an_state == an_pkg::AN_LINK_OK); // Holds the watchdog

   lacr_rx_filter u_filter (.rx_clk, .an_rst, .los, .lacr_in, .lacr_in_stb, .an_state,
      .link_det, .match_ok, .abl_match, .ack_match, .consistency_match,
      .breaklink_seen, .lacr_prev, .lacr_ability);

   an_timers #(.TIMER_TICKS(TIMER_TICKS)) u_timers (.rx_clk, .an_rst, .los, .link_det,
      .link_timer_start, .fwd_progress, .link_ok, .link_timer_on, .link_timer_done,
      .wdog_timeout, .wdog_an_disable);

   an_arbiter u_arbiter (.rx_clk, .an_rst, .los, .link_det, .abl_match, .ack_match,
      .consistency_match, .breaklink_seen, .link_timer_on, .link_timer_done,
      .wdog_timeout, .wdog_an_disable, .an_state, .link_timer_start, .fwd_progress,
      .lacr_send, .send_ack, .send_breaklink, .operate);

   lacr_tx_encode u_encode (.rx_clk, .an_rst, .send_ack, .send_breaklink, .an_state,
      .wdog_an_disable, .match_ok, .lacr_prev, .lacr_ability, .lacr_out, .an_status);

endmodule

//--- logic/lacr_rx_filter.sv
`timescale 1ns/10ps
//############################################################
// Receive filter for partner config words
// Three-in-a-row match, ability capture, ack and consistency
// Link presence and breaklink detection
//############################################################
module lacr_rx_filter (
   input  logic              rx_clk,
   input  logic              an_rst,
   input  logic              los,
   input  an_pkg::lacr_t     lacr_in,
   input  logic              lacr_in_stb,
   input  an_pkg::an_state_e an_state,
   output logic              link_det,
   output logic              match_ok,
   output logic              abl_match,
   output logic              ack_match,
   output logic              consistency_match,
   output logic              breaklink_seen,
   output an_pkg::lacr_t     lacr_prev,
   output an_pkg::lacr_t     lacr_ability
);
   logic          stb_d;   // Compare stage valid
   an_pkg::lacr_t word_d;  // Compare stage word
   logic [1:0]    run_cnt; // Equal words so far
   logic [1:0]    brk_cnt; // Zero words in a row, saturates
   logic          in_restart;

   assign in_restart = (an_state == an_pkg::AN_RESTART);

   always_ff @(posedge rx_clk) begin
      if (an_rst || los) begin
         link_det <= 1'b0;
      end else if (lacr_in_stb) begin
         link_det <= 1'b1; // Any word means a partner is there
      end
   end

   // Words are compared one cycle after their strobe
   always_ff @(posedge rx_clk) begin
      if (an_rst) begin
         stb_d <= 1'b0;
      end else begin
         stb_d <= lacr_in_stb;
      end
      word_d <= lacr_in;
   end

   always_ff @(posedge rx_clk) begin
      if (an_rst) begin
         run_cnt   <= 2'd0;
         match_ok  <= 1'b0;
         lacr_prev <= '0;
      end else begin
         match_ok <= 1'b0;
         if (stb_d) lacr_prev <= word_d;
         if (in_restart) begin
            run_cnt <= 2'd0; // Start counting afresh after restart
         end else if (stb_d) begin
            if (word_d != lacr_prev) begin
               run_cnt <= 2'd1;
            end else if (run_cnt == 2'd2) begin
               run_cnt  <= 2'd0;
               match_ok <= 1'b1; // Third in a row
            end else begin
               run_cnt <= run_cnt + 2'd1;
            end
         end
      end
   end

   // Flags, cleared throughout restart
   always_ff @(posedge rx_clk) begin
      if (an_rst || in_restart) begin
         abl_match         <= 1'b0;
         ack_match         <= 1'b0;
         consistency_match <= 1'b0;
      end else if (match_ok) begin
         if (an_state == an_pkg::AN_ABILITY && !lacr_prev[an_pkg::ACK_BIT])
            abl_match <= 1'b1;
         if (an_state == an_pkg::AN_ACK && lacr_prev[an_pkg::ACK_BIT] && !ack_match) begin
            ack_match         <= 1'b1;
            consistency_match <= (lacr_prev == lacr_ability); // Same word, now acked
         end
      end
   end

   // Ability stored with ack forced on, compared later against the acked word
   always_ff @(posedge rx_clk) begin
      if (an_rst) begin
         lacr_ability <= an_pkg::LOCAL_ABILITY | an_pkg::lacr_t'(1 << an_pkg::ACK_BIT);
      end else if (match_ok && an_state == an_pkg::AN_ABILITY &&
                   !lacr_prev[an_pkg::ACK_BIT]) begin
         lacr_ability                  <= lacr_prev;
         lacr_ability[an_pkg::ACK_BIT] <= 1'b1;
      end
   end

   always_ff @(posedge rx_clk) begin
      if (an_rst) begin
         brk_cnt <= 2'd0;
      end else if (lacr_in_stb) begin
         if (lacr_in != '0) brk_cnt <= 2'd0;
         else if (brk_cnt != 2'd3) brk_cnt <= brk_cnt + 2'd1;
      end
   end
   assign breaklink_seen = (brk_cnt == 2'd3); // Holds until a non-zero word

   // Ability match only ever set from the ability detect state
   a_abl_not_in_restart: assert property (@(posedge rx_clk) disable iff (an_rst)
      $rose(abl_match) |-> $past(an_state) != an_pkg::AN_RESTART);

endmodule

//--- logic/lacr_tx_encode.sv
`timescale 1ns/10ps
//############################################################
// Transmit config word builder
// Registered status vector for management
//############################################################
module lacr_tx_encode (
   input  logic               rx_clk,
   input  logic               an_rst,
   input  logic               send_ack,
   input  logic               send_breaklink,
   input  an_pkg::an_state_e  an_state,
   input  logic               wdog_an_disable,
   input  logic               match_ok,
   input  an_pkg::lacr_t      lacr_prev,
   input  an_pkg::lacr_t      lacr_ability,
   output an_pkg::lacr_t      lacr_out,
   output an_pkg::an_status_t an_status
);
   // Zero word during breaklink, else local ability plus ack
   always_comb begin
      lacr_out                  = an_pkg::LOCAL_ABILITY;
      lacr_out[an_pkg::ACK_BIT] = send_ack;
      if (send_breaklink) lacr_out = '0;
   end

   always_ff @(posedge rx_clk) begin
      if (an_rst) begin
         an_status <= '0;
      end else begin
         an_status[an_pkg::ST_ABORT]    <= (an_state == an_pkg::AN_ABORT);
         an_status[an_pkg::ST_ABILITY]  <= (an_state == an_pkg::AN_ABILITY);
         an_status[an_pkg::ST_WDOG_DIS] <= wdog_an_disable;
         // Remote fault taken only from a word seen three times
         if (match_ok) begin
            an_status[an_pkg::ST_RF2] <= lacr_prev[an_pkg::RF2_BIT];
            an_status[an_pkg::ST_RF1] <= lacr_prev[an_pkg::RF1_BIT];
         end
         an_status[an_pkg::ST_ABL_MISMATCH] <= !lacr_ability[an_pkg::FD_BIT];
         an_status[an_pkg::ST_ACK]     <= (an_state == an_pkg::AN_ACK);
         an_status[an_pkg::ST_IDLE]    <= (an_state == an_pkg::AN_IDLE);
         an_status[an_pkg::ST_LINK_OK] <= (an_state == an_pkg::AN_LINK_OK);
      end
   end

endmodule

//--- sim/an_stimulus.txt
# test kind word arg los, then expected lacr_out operate lacr_send an_status (words in hex)
# arg is the repeat count for send, or the an_status bit that wait polls for
1 send 0000 0  0 0000 0 1 000
2 wait 0020 7  0 0020 0 1 080
2 wait 0020 2  0 4020 0 1 004
2 wait 4020 1  0 4020 0 0 002
2 wait 4020 0  0 0020 1 0 001
3 send 4020 2  0 0020 1 0 001
3 send 0000 1  0 0020 1 0 001
3 send 4020 2  0 0020 1 0 001
3 send 0000 3  0 0000 0 1 000
4 wait 0020 7  0 0020 0 1 080
4 wait 0020 2  0 4020 0 1 004
4 wait 4020 0  0 0020 1 0 001
4 send 4020 3  1 0000 0 1 000
4 send 4020 10 1 0000 0 1 000
5 wait 0020 7  0 0020 0 1 080
5 wait 0020 2  0 4020 0 1 004
5 wait 4060 7  0 0020 0 1 080
5 wait 0040 2  0 4020 0 1 00c
5 send 2040 3  0 4020 0 1 02c
5 send 1040 3  0 4020 0 1 01c
6 wait 0020 6  0 0000 0 1 048
6 wait 0020 8  0 0020 1 0 148
6 send 0020 3  1 0000 0 1 008

//--- sim/an_tb.sv
`timescale 1ns/10ps
//############################################################
// Testbench for the auto-negotiation top level
// Link partner played from the stimulus file
// Compare tasks, cycle limit, per-test result lines
//############################################################
module an_tb;
   localparam int    TIMER_TICKS   = 16;
   localparam int    SETTLE_CYCLES = 6; // Strobe to status path is five cycles
   localparam string STIM_FILE     = "sim/an_stimulus.txt";

   logic               rx_clk;
   logic               an_rst;
   logic               los;
   an_pkg::lacr_t      lacr_in;
   logic               lacr_in_stb;
   an_pkg::lacr_t      lacr_out;
   logic               lacr_send;
   logic               operate;
   an_pkg::an_status_t an_status;

   // One entry per stimulus step
   int                 step_test[$];
   bit                 step_wait[$];  // Poll a status bit
   an_pkg::lacr_t      step_word[$];  // Partner word
   int                 step_arg[$];   // Repeat count or status bit
   logic               step_los[$];
   an_pkg::lacr_t      exp_lacr[$];
   logic               exp_oper[$];
   logic               exp_send[$];
   an_pkg::an_status_t exp_status[$];

   int cycle_cnt   = 0;
   int cycle_limit = 0;
   bit limit_set   = 1'b0;
   int error_cnt   = 0;
   int test_errs   = 0;  // Errors in the running test
   bit load_ok;
   int unsigned seed_rnd;

   tb_clock_gen clk_gen_inst (.rx_clk(rx_clk), .an_rst(an_rst));

   an_top #(.TIMER_TICKS(TIMER_TICKS)) an_top_inst (
      .rx_clk(rx_clk), .an_rst(an_rst), .los(los), .lacr_in(lacr_in),
      .lacr_in_stb(lacr_in_stb), .lacr_out(lacr_out), .lacr_send(lacr_send),
      .operate(operate), .an_status(an_status));

   // Run limit
   always @(posedge rx_clk) begin
      cycle_cnt <= cycle_cnt + 1;
      if (limit_set && cycle_cnt >= cycle_limit) begin
         $display("Timeout after %0d cycles, the DUT never reached the expected state",
                  cycle_cnt);
         $display("TB FAILED");
         $finish;
      end
   end

   task automatic tick();
      @(negedge rx_clk); // Inputs change here, outputs are stable
   endtask

   task automatic settle();
      repeat (SETTLE_CYCLES) tick();
   endtask

   task automatic load_stimulus(output int reps_sum);
      int                 fd;
      int                 n;
      string              line;
      string              kind;
      int                 t_num, arg, los_v, oper_v, send_v;
      an_pkg::lacr_t      word, lacr_v;
      an_pkg::an_status_t status_v;
      reps_sum = 0;
      load_ok  = 1'b1;
      fd = $fopen(STIM_FILE, "r");
      if (fd == 0) begin
         $display("Cannot open %s for reading", STIM_FILE);
         load_ok = 1'b0;
      end else begin
         while (!$feof(fd)) begin
            line = "";
            n = $fgets(line, fd);
            if (n > 0 && line.len() > 1 && line[0] != "#") begin // Skip comments
               n = $sscanf(line, "%d %s %h %d %d %h %d %d %h", t_num, kind, word, arg,
                           los_v, lacr_v, oper_v, send_v, status_v);
               if (n != 9 || (kind != "wait" && kind != "send")) begin
                  $display("Malformed stimulus line: %s", line);
                  load_ok = 1'b0;
               end else begin
                  step_test.push_back(t_num);
                  step_wait.push_back(kind == "wait");
                  step_word.push_back(word);
                  step_arg.push_back(arg);
                  step_los.push_back(los_v[0]);
                  exp_lacr.push_back(lacr_v);
                  exp_oper.push_back(oper_v[0]);
                  exp_send.push_back(send_v[0]);
                  exp_status.push_back(status_v);
                  if (kind == "send") reps_sum += arg;
               end
            end
         end
         $fclose(fd);
      end
   endtask

   // Strobe, then an idle gap of 1 to 3 cycles
   task automatic send_words(input an_pkg::lacr_t word, input int reps);
      int i;
      int gap;
      lacr_in = word;
      for (i = 0; i < reps; i++) begin
         lacr_in_stb = 1'b1;
         tick();
         lacr_in_stb = 1'b0;
         gap = 1 + ($urandom % 3);
         repeat (gap) tick();
      end
   endtask

   // Keeps the partner talking until the status bit shows up
   task automatic wait_for_bit(input an_pkg::lacr_t word, input int bit_idx);
      int   gap_left;
      logic found;
      gap_left = 0;
      found    = 1'b0;
      lacr_in  = word;
      while (!found) begin
         if (gap_left == 0) begin
            lacr_in_stb = 1'b1;
            gap_left    = 1 + ($urandom % 3);
         end else begin
            lacr_in_stb = 1'b0;
            gap_left    = gap_left - 1;
         end
         tick();
         found = (an_status[bit_idx] === 1'b1);
      end
      lacr_in_stb = 1'b0;
   endtask

   task automatic check_lacr(input string name, input an_pkg::lacr_t got,
                             input an_pkg::lacr_t exp);
      if (got !== exp) begin
         $display("CHECK FAILED at time %0t: %s is %h, expected %h", $time, name, got, exp);
         error_cnt++;
         test_errs++;
      end
   endtask

   task automatic check_status(input string name, input an_pkg::an_status_t got,
                               input an_pkg::an_status_t exp);
      if (got !== exp) begin
         $display("CHECK FAILED at time %0t: %s is %h, expected %h", $time, name, got, exp);
         error_cnt++;
         test_errs++;
      end
   endtask

   task automatic check_bit(input string name, input logic got, input logic exp);
      if (got !== exp) begin
         $display("CHECK FAILED at time %0t: %s is %b, expected %b", $time, name, got, exp);
         error_cnt++;
         test_errs++;
      end
   endtask

   task automatic report_test(input int num);
      $display("Test %0d finished with %0d errors", num, test_errs);
      test_errs = 0;
   endtask

   initial begin
      int          reps_sum;
      int          cur_test;
      int          test_cnt;
      int          k;
      int unsigned seed;
      los         = 1'b0;
      lacr_in     = '0;
      lacr_in_stb = 1'b0;
      seed        = 32'hbcd;
      seed_rnd    = $urandom(seed); // Only seeding, gaps come later
      cur_test    = -1;
      test_cnt    = 0;
      load_stimulus(reps_sum);
      if (!load_ok) begin
         $display("Stimulus could not be loaded, no test was run");
         error_cnt++;
      end else begin
         cycle_limit = reps_sum * 4 + 40 * TIMER_TICKS; // Four cycles per word at most
         limit_set   = 1'b1;
         wait (an_rst === 1'b0);
         tick();
         for (k = 0; k < step_test.size(); k++) begin
            if (step_test[k] != cur_test) begin
               if (cur_test >= 0) report_test(cur_test);
               cur_test = step_test[k];
               test_cnt++;
            end
            los = step_los[k];
            if (step_wait[k]) wait_for_bit(step_word[k], step_arg[k]);
            else send_words(step_word[k], step_arg[k]);
            settle();
            check_lacr("lacr_out", lacr_out, exp_lacr[k]);
            check_bit("operate", operate, exp_oper[k]);
            check_bit("lacr_send", lacr_send, exp_send[k]);
            check_status("an_status", an_status, exp_status[k]);
         end
         if (cur_test >= 0) report_test(cur_test);
      end
      $display("Tests run: %0d, steps: %0d, errors: %0d", test_cnt, step_test.size(),
               error_cnt);
      if (error_cnt == 0) begin
         $display("TB PASSED");
      end else begin
         $display("TB FAILED");
      end
      $finish;
   end

endmodule

//--- sim/tb_clock_gen.sv
`timescale 1ns/10ps
//############################################################
// Clock and reset source for the testbench
// rx_clk at 40 ns, an_rst held for three cycles
//############################################################
module tb_clock_gen #(
   parameter int PERIOD_NS    = 40,
   parameter int RESET_CYCLES = 3
) (
   output logic rx_clk,
   output logic an_rst
);
   initial begin
      rx_clk = 1'b0;
      forever #(PERIOD_NS / 2) rx_clk = ~rx_clk;
   end

   // Released on a falling edge, clear of the sampling edge
   initial begin
      an_rst = 1'b1;
      repeat (RESET_CYCLES) @(posedge rx_clk);
      @(negedge rx_clk);
      an_rst = 1'b0;
   end

endmodule
